// ==== design/csi2_pkg.sv ====
package csi2_pkg;

	// ---------------------------------------------------------
	// lane and pixel widths
	// ---------------------------------------------------------

	// one byte from one D-PHY lane
	typedef logic [7:0]  byte_t;

	// lane 0 byte in [7:0], lane 1 byte in [15:8]
	typedef logic [15:0] lane_word_t;

	typedef logic [9:0]  pixel_t;

	// pixel 0 in the low bits
	typedef logic [39:0] pixel_group_t;

	// ---------------------------------------------------------
	// packet header fields
	// ---------------------------------------------------------

	typedef logic [5:0]  data_type_t;

	// payload length in bytes
	typedef logic [15:0] word_count_t;

	// short packets
	localparam data_type_t DT_FRAME_START = 6'h00;
	localparam data_type_t DT_FRAME_END   = 6'h01;

	// long packets
	localparam data_type_t DT_RAW10       = 6'h2b;

endpackage

// ==== design/csi2_lane_merge.sv ====
`timescale 1ns/1ps

module csi2_lane_merge #(
	parameter int SKEW_DEPTH = 4
) (
	input  logic                rxbyteclkhs,
	input  logic                rst_n_i,
	input  csi2_pkg::lane_word_t rxdatahs_i,
	input  logic [1:0]          rxvalidhs_i,
	input  logic [1:0]          rxactivehs_i,
	input  logic [1:0]          rxsynchs_i,
	output csi2_pkg::lane_word_t word_o,
	output logic                word_valid_o,
	output logic                pkt_active_o
);

	localparam int PTR_W = (SKEW_DEPTH > 1) ? $clog2(SKEW_DEPTH) : 1;
	localparam int CNT_W = $clog2(SKEW_DEPTH + 1);

	logic [1:0]      lane_avail;
	csi2_pkg::byte_t lane_head [2];
	logic            pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(SKEW_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// both lanes hold a byte, so a word goes out
	assign pop = &lane_avail;

	// ---------------------------------------------------------
	// per-lane skew buffers
	// ---------------------------------------------------------

	for (genvar l = 0; l < 2; l++) begin : g_lane
		csi2_pkg::byte_t  mem [SKEW_DEPTH];
		csi2_pkg::byte_t  din;
		logic [PTR_W-1:0] wr_ptr;
		logic [PTR_W-1:0] rd_ptr;
		logic [CNT_W-1:0] cnt;
		logic             empty;
		logic             store;
		logic             take;

		assign din   = rxdatahs_i[8*l +: 8];
		assign empty = (cnt == '0);

		// nothing is offered while the lane restarts
		assign lane_avail[l] = !rxsynchs_i[l] && (!empty || rxvalidhs_i[l]);
		assign lane_head[l]  = empty ? din : mem[rd_ptr];

		// a byte that passes straight through is not stored
		assign store = rxvalidhs_i[l] && !(pop && empty);
		assign take  = pop && !empty;

		always_ff @(posedge rxbyteclkhs) begin
			if (store)
				mem[wr_ptr] <= din;
		end

		always_ff @(posedge rxbyteclkhs) begin
			if (!rst_n_i || rxsynchs_i[l]) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				cnt    <= '0;
			end else begin
				if (store)
					wr_ptr <= next_ptr(wr_ptr);
				if (take)
					rd_ptr <= next_ptr(rd_ptr);
				cnt <= cnt + CNT_W'(store) - CNT_W'(take);
			end
		end

		// lane skew larger than the buffer would lose bytes
		a_no_overflow: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n_i)
			store |-> cnt < CNT_W'(SKEW_DEPTH))
			else $error("lane %0d skew buffer overflow", l);
	end

	always_ff @(posedge rxbyteclkhs) begin
		if (!rst_n_i) begin
			word_valid_o <= 1'b0;
			pkt_active_o <= 1'b0;
		end else begin
			word_valid_o <= pop;
			if (pop)
				pkt_active_o <= 1'b1;
			else if (rxactivehs_i == 2'b00)
				pkt_active_o <= 1'b0;
		end
	end

	always_ff @(posedge rxbyteclkhs) begin
		if (pop)
			word_o <= {lane_head[1], lane_head[0]};
	end

endmodule

// ==== design/csi2_packet_parser.sv ====
`timescale 1ns/1ps

module csi2_packet_parser (
	input  logic                 rxbyteclkhs,
	input  logic                 rst_n_i,
	input  csi2_pkg::lane_word_t word_i,
	input  logic                 word_valid_i,
	input  logic                 pkt_active_i,
	output csi2_pkg::lane_word_t payload_o,
	output logic                 payload_valid_o,
	output logic                 payload_last_o,
	output logic                 frame_start_o,
	output logic                 frame_end_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HEADER,
		ST_PAYLOAD,
		ST_SKIP
	} state_t;

	state_t                state;
	csi2_pkg::data_type_t  dt;
	csi2_pkg::byte_t       wc_lo;
	csi2_pkg::word_count_t wc;
	csi2_pkg::word_count_t remain;

	// word count high byte sits in the low half of the second word
	assign wc = {word_i[7:0], wc_lo};

	// ---------------------------------------------------------
	// header capture
	// ---------------------------------------------------------

	always_ff @(posedge rxbyteclkhs) begin
		if (state == ST_IDLE && word_valid_i) begin
			dt    <= word_i[5:0];
			wc_lo <= word_i[15:8];
		end
	end

	always_ff @(posedge rxbyteclkhs) begin
		if (state == ST_PAYLOAD && word_valid_i)
			payload_o <= word_i;
	end

	// ---------------------------------------------------------
	// packet FSM
	// ---------------------------------------------------------

	always_ff @(posedge rxbyteclkhs) begin
		if (!rst_n_i) begin
			state           <= ST_IDLE;
			remain          <= '0;
			payload_valid_o <= 1'b0;
			payload_last_o  <= 1'b0;
			frame_start_o   <= 1'b0;
			frame_end_o     <= 1'b0;
		end else begin
			payload_valid_o <= 1'b0;
			payload_last_o  <= 1'b0;
			frame_start_o   <= 1'b0;
			frame_end_o     <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (word_valid_i)
						state <= ST_HEADER;
				end
				ST_HEADER: begin
					if (word_valid_i) begin
						state <= ST_SKIP;
						case (dt)
							csi2_pkg::DT_FRAME_START: frame_start_o <= 1'b1;
							csi2_pkg::DT_FRAME_END:   frame_end_o   <= 1'b1;
							csi2_pkg::DT_RAW10: begin
								if (wc != '0) begin
									remain <= wc >> 1;
									state  <= ST_PAYLOAD;
								end
							end
							default: ;
						endcase
					end
				end
				ST_PAYLOAD: begin
					if (word_valid_i) begin
						payload_valid_o <= 1'b1;
						payload_last_o  <= (remain == 16'd1);
						remain          <= remain - 1'b1;
						// CRC bytes after the payload are dropped in skip
						if (remain == 16'd1)
							state <= ST_SKIP;
					end
				end
				default: ;
			endcase

			// end of burst closes even a truncated packet
			if (!pkt_active_i)
				state <= ST_IDLE;
		end
	end

	a_payload_in_state: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n_i)
		payload_valid_o |-> $past(state) == ST_PAYLOAD && $past(remain) != '0)
		else $error("payload strobe outside payload state or past the word count");

endmodule

// ==== design/raw10_unpack.sv ====
`timescale 1ns/1ps

module raw10_unpack (
	input  logic                   rxbyteclkhs,
	input  logic                   rst_n_i,
	input  csi2_pkg::lane_word_t   payload_i,
	input  logic                   payload_valid_i,
	input  logic                   payload_last_i,
	input  logic                   frame_start_i,
	output csi2_pkg::pixel_group_t pix_data_o,
	output logic                   pix_valid_o,
	output logic                   pix_user_o,
	output logic                   pix_last_o
);

	csi2_pkg::byte_t        acc [4];
	csi2_pkg::byte_t        grp [5];
	csi2_pkg::pixel_t       pix [4];
	csi2_pkg::pixel_group_t group;
	csi2_pkg::byte_t        lo;
	csi2_pkg::byte_t        hi;
	logic [2:0]             phase;
	logic                   first_pending;
	logic                   emit;

	assign lo = payload_i[7:0];
	assign hi = payload_i[15:8];

	// byte 4 lands in this word when phase is 3 or 4
	assign emit = payload_valid_i && (phase >= 3'd3);

	always_comb begin
		for (int k = 0; k < 4; k++)
			grp[k] = acc[k];
		grp[4] = lo;
		if (phase == 3'd3) begin
			grp[3] = lo;
			grp[4] = hi;
		end
		// byte 4 carries the two lsbs of every pixel
		for (int k = 0; k < 4; k++)
			pix[k] = {grp[k], grp[4][2*k +: 2]};
		group = {pix[3], pix[2], pix[1], pix[0]};
	end

	always_ff @(posedge rxbyteclkhs) begin
		if (payload_valid_i) begin
			case (phase)
				3'd3: ;
				3'd4: acc[0] <= hi;
				default: begin
					acc[phase[1:0]]        <= lo;
					acc[phase[1:0] + 2'd1] <= hi;
				end
			endcase
		end
	end

	always_ff @(posedge rxbyteclkhs) begin
		if (!rst_n_i) begin
			phase         <= 3'd0;
			first_pending <= 1'b0;
			pix_data_o    <= '0;
			pix_valid_o   <= 1'b0;
			pix_user_o    <= 1'b0;
			pix_last_o    <= 1'b0;
		end else begin
			pix_valid_o <= emit;
			pix_user_o  <= emit && first_pending;
			pix_last_o  <= emit && payload_last_i;
			if (emit)
				pix_data_o <= group;

			if (frame_start_i)
				first_pending <= 1'b1;
			else if (emit)
				first_pending <= 1'b0;

			// next line starts at byte 0
			if (frame_start_i || (payload_valid_i && payload_last_i))
				phase <= 3'd0;
			else if (payload_valid_i)
				phase <= (phase >= 3'd3) ? phase - 3'd3 : phase + 3'd2;
		end
	end

	a_no_back_to_back: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n_i)
		pix_valid_o |=> !pix_valid_o)
		else $error("pixel groups on consecutive cycles");

endmodule

// ==== design/frame_monitor.sv ====
`timescale 1ns/1ps

module frame_monitor #(
	parameter int COUNT_WIDTH = 32
) (
	input  logic                   rxbyteclkhs,
	input  logic                   rst_n_i,
	input  logic [1:0]             rxactivehs_i,
	input  logic [1:0]             rxsynchs_i,
	input  logic                   frame_start_i,
	input  logic                   frame_end_i,
	input  logic                   line_end_i,
	output logic [COUNT_WIDTH-1:0] lane0_count_o,
	output logic [COUNT_WIDTH-1:0] lane1_count_o,
	output logic                   frame_toggle_o,
	output logic [COUNT_WIDTH-1:0] frame_count_o,
	output logic [COUNT_WIDTH-1:0] line_count_o
);

	logic [COUNT_WIDTH-1:0] lane_cnt [2];
	logic [COUNT_WIDTH-1:0] line_cnt;

	assign lane0_count_o = lane_cnt[0];
	assign lane1_count_o = lane_cnt[1];

	// lane activity since the last sync
	always_ff @(posedge rxbyteclkhs) begin
		if (!rst_n_i) begin
			lane_cnt[0] <= '0;
			lane_cnt[1] <= '0;
		end else begin
			for (int l = 0; l < 2; l++) begin
				if (rxsynchs_i[l])
					lane_cnt[l] <= '0;
				else if (rxactivehs_i[l])
					lane_cnt[l] <= lane_cnt[l] + 1'b1;
			end
		end
	end

	always_ff @(posedge rxbyteclkhs) begin
		if (!rst_n_i) begin
			frame_toggle_o <= 1'b0;
			frame_count_o  <= '0;
			line_cnt       <= '0;
			line_count_o   <= '0;
		end else begin
			if (frame_start_i) begin
				frame_toggle_o <= ~frame_toggle_o;
				line_cnt       <= '0;
			end else if (line_end_i) begin
				line_cnt <= line_cnt + 1'b1;
			end
			// lines of the frame just closed
			if (frame_end_i) begin
				frame_count_o <= frame_count_o + 1'b1;
				line_count_o  <= line_cnt;
			end
		end
	end

endmodule

// ==== design/csi2_cam_rx.sv ====
`timescale 1ns/1ps

module csi2_cam_rx #(
	parameter int SKEW_DEPTH  = 4,
	parameter int COUNT_WIDTH = 32
) (
	input  logic                   rxbyteclkhs,
	input  logic                   rst_n_i,

	// two-lane D-PHY byte side, lane 1 in the high byte
	input  csi2_pkg::lane_word_t   rxdatahs_i,
	input  logic [1:0]             rxvalidhs_i,
	input  logic [1:0]             rxactivehs_i,
	input  logic [1:0]             rxsynchs_i,

	output csi2_pkg::pixel_group_t pix_data_o,
	output logic                   pix_valid_o,
	output logic                   pix_user_o,
	output logic                   pix_last_o,

	output logic [COUNT_WIDTH-1:0] lane0_count_o,
	output logic [COUNT_WIDTH-1:0] lane1_count_o,
	output logic                   frame_toggle_o,
	output logic [COUNT_WIDTH-1:0] frame_count_o,
	output logic [COUNT_WIDTH-1:0] line_count_o
);

	csi2_pkg::lane_word_t word;
	logic                 word_valid;
	logic                 pkt_active;
	csi2_pkg::lane_word_t payload;
	logic                 payload_valid;
	logic                 payload_last;
	logic                 frame_start;
	logic                 frame_end;

	// ---------------------------------------------------------
	// lane merge and packet layer
	// ---------------------------------------------------------

	csi2_lane_merge #(
		.SKEW_DEPTH   (SKEW_DEPTH)
	) u_lane_merge (
		.rxbyteclkhs  (rxbyteclkhs),
		.rst_n_i      (rst_n_i),
		.rxdatahs_i   (rxdatahs_i),
		.rxvalidhs_i  (rxvalidhs_i),
		.rxactivehs_i (rxactivehs_i),
		.rxsynchs_i   (rxsynchs_i),
		.word_o       (word),
		.word_valid_o (word_valid),
		.pkt_active_o (pkt_active)
	);

	csi2_packet_parser u_packet_parser (
		.rxbyteclkhs     (rxbyteclkhs),
		.rst_n_i         (rst_n_i),
		.word_i          (word),
		.word_valid_i    (word_valid),
		.pkt_active_i    (pkt_active),
		.payload_o       (payload),
		.payload_valid_o (payload_valid),
		.payload_last_o  (payload_last),
		.frame_start_o   (frame_start),
		.frame_end_o     (frame_end)
	);

	// ---------------------------------------------------------
	// pixels and monitor
	// ---------------------------------------------------------

	raw10_unpack u_raw10_unpack (
		.rxbyteclkhs     (rxbyteclkhs),
		.rst_n_i         (rst_n_i),
		.payload_i       (payload),
		.payload_valid_i (payload_valid),
		.payload_last_i  (payload_last),
		.frame_start_i   (frame_start),
		.pix_data_o      (pix_data_o),
		.pix_valid_o     (pix_valid_o),
		.pix_user_o      (pix_user_o),
		.pix_last_o      (pix_last_o)
	);

	// payload_last is only ever high together with its valid strobe
	frame_monitor #(
		.COUNT_WIDTH    (COUNT_WIDTH)
	) u_frame_monitor (
		.rxbyteclkhs    (rxbyteclkhs),
		.rst_n_i        (rst_n_i),
		.rxactivehs_i   (rxactivehs_i),
		.rxsynchs_i     (rxsynchs_i),
		.frame_start_i  (frame_start),
		.frame_end_i    (frame_end),
		.line_end_i     (payload_last),
		.lane0_count_o  (lane0_count_o),
		.lane1_count_o  (lane1_count_o),
		.frame_toggle_o (frame_toggle_o),
		.frame_count_o  (frame_count_o),
		.line_count_o   (line_count_o)
	);

endmodule

// ==== include/csi2_tb_tasks.svh ====
// ----------------------------------------------------------
// lane drive
// ----------------------------------------------------------

// even bytes on lane 0, odd bytes on lane 1, lane 1 late by skew
task automatic drive_lanes(input int skew);
	int                   n;
	int                   rel;
	csi2_pkg::lane_word_t data;
	logic [1:0]           valid;
	logic [1:0]           active;
	logic [1:0]           sync;
	n = pkt.size() / 2;
	for (int c = 0; c <= n + skew; c++) begin
		data   = '0;
		valid  = '0;
		active = '0;
		sync   = '0;
		for (int l = 0; l < 2; l++) begin
			rel = (l == 1) ? c - skew : c;
			if (rel == 0) begin
				sync[l]   = 1'b1;
				active[l] = 1'b1;
			end else if (rel >= 1 && rel <= n) begin
				valid[l]       = 1'b1;
				active[l]      = 1'b1;
				data[8*l +: 8] = pkt[2*(rel-1) + l];
			end
		end
		@(posedge rxbyteclkhs);
		rxdatahs   <= data;
		rxvalidhs  <= valid;
		rxactivehs <= active;
		rxsynchs   <= sync;
	end
	@(posedge rxbyteclkhs);
	rxdatahs   <= '0;
	rxvalidhs  <= '0;
	rxactivehs <= '0;
	rxsynchs   <= '0;
	// gap so the burst closes before the next sync
	repeat (4) @(posedge rxbyteclkhs);
	lane_active = 32'(n);
endtask

task automatic short_packet(input csi2_pkg::data_type_t dt, input int skew);
	pkt.delete();
	pkt.push_back({2'b00, dt});
	repeat (3) pkt.push_back(8'h00);
	drive_lanes(skew);
endtask

task automatic long_packet(input csi2_pkg::data_type_t dt, input int skew);
	csi2_pkg::word_count_t wc;
	wc = 16'(payload_q.size());
	pkt.delete();
	pkt.push_back({2'b00, dt});
	pkt.push_back(wc[7:0]);
	pkt.push_back(wc[15:8]);
	pkt.push_back(8'h00);
	foreach (payload_q[i])
		pkt.push_back(payload_q[i]);
	// two crc bytes the receiver skips
	repeat (2) pkt.push_back(8'h00);
	drive_lanes(skew);
endtask

// ----------------------------------------------------------
// RAW10 reference model
// ----------------------------------------------------------

task automatic expect_line(input logic first);
	int                     groups;
	csi2_pkg::byte_t        b4;
	csi2_pkg::pixel_group_t group;
	groups = payload_q.size() / 5;
	for (int g = 0; g < groups; g++) begin
		b4 = payload_q[5*g + 4];
		// upper eight bits from b0..b3, two lsbs each from b4
		for (int k = 0; k < 4; k++)
			group[10*k +: 10] = {payload_q[5*g + k], b4[2*k +: 2]};
		expect_q.push_back({first && g == 0, g == groups - 1, group});
		final_group = group;
	end
endtask

task automatic send_frame(input int lines, input csi2_pkg::data_type_t dt, input int skew);
	short_packet(csi2_pkg::DT_FRAME_START, skew);
	fs_sent = fs_sent + 1'b1;
	for (int i = 0; i < lines; i++) begin
		payload_q.delete();
		for (int j = 0; j < WORD_COUNT; j++)
			payload_q.push_back(line_data[i][j]);
		if (dt == csi2_pkg::DT_RAW10)
			expect_line(i == 0);
		long_packet(dt, skew);
	end
	short_packet(csi2_pkg::DT_FRAME_END, skew);
	fe_sent    = fe_sent + 1'b1;
	last_lines = (dt == csi2_pkg::DT_RAW10) ? 32'(lines) : 32'd0;
endtask

// ==== tb/tb_csi2_cam_rx.sv ====
`timescale 1ns/1ps

module tb_csi2_cam_rx;

	localparam int SEED       = 37739;
	localparam int LINES      = 3;
	localparam int WORD_COUNT = 40;
	localparam int TIMEOUT    = 1000;

	logic                   rxbyteclkhs;
	logic                   rst_n;
	csi2_pkg::lane_word_t   rxdatahs;
	logic [1:0]             rxvalidhs;
	logic [1:0]             rxactivehs;
	logic [1:0]             rxsynchs;
	csi2_pkg::pixel_group_t pix_data;
	logic                   pix_valid;
	logic                   pix_user;
	logic                   pix_last;
	logic [31:0]            lane0_count;
	logic [31:0]            lane1_count;
	logic                   frame_toggle;
	logic [31:0]            frame_count;
	logic [31:0]            line_count;

	csi2_pkg::byte_t        line_data [LINES][WORD_COUNT];
	csi2_pkg::byte_t        pkt [$];
	csi2_pkg::byte_t        payload_q [$];
	// user, last, group
	logic [41:0]            expect_q [$];
	csi2_pkg::pixel_group_t exp_group;
	logic                   exp_user;
	logic                   exp_last;
	logic                   exp_pending;
	csi2_pkg::pixel_group_t final_group;
	logic [31:0]            fs_sent;
	logic [31:0]            fe_sent;
	logic [31:0]            last_lines;
	logic [31:0]            lane_active;
	logic                   check_idle;
	int                     seed;
	int                     errors;
	int                     errors_before;
	int                     tests;
	int                     failed;

	csi2_cam_rx #(
		.SKEW_DEPTH     (4),
		.COUNT_WIDTH    (32)
	) dut (
		.rxbyteclkhs    (rxbyteclkhs),
		.rst_n_i        (rst_n),
		.rxdatahs_i     (rxdatahs),
		.rxvalidhs_i    (rxvalidhs),
		.rxactivehs_i   (rxactivehs),
		.rxsynchs_i     (rxsynchs),
		.pix_data_o     (pix_data),
		.pix_valid_o    (pix_valid),
		.pix_user_o     (pix_user),
		.pix_last_o     (pix_last),
		.lane0_count_o  (lane0_count),
		.lane1_count_o  (lane1_count),
		.frame_toggle_o (frame_toggle),
		.frame_count_o  (frame_count),
		.line_count_o   (line_count)
	);

	initial begin
		rxbyteclkhs = 1'b0;
		forever #4 rxbyteclkhs = ~rxbyteclkhs;
	end

	`include "csi2_tb_tasks.svh"

	// one reference entry consumed per output group
	always @(posedge rxbyteclkhs) begin
		if (pix_valid && expect_q.size() > 0)
			void'(expect_q.pop_front());
		exp_pending <= (expect_q.size() > 0);
		if (expect_q.size() > 0)
			{exp_user, exp_last, exp_group} <= expect_q[0];
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------

	a_expected: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n)
		pix_valid |-> exp_pending)
		else begin
			errors++;
			$display("pixel group at %0t when no group was expected", $time);
		end

	a_data: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n)
		pix_valid && exp_pending |-> pix_data == exp_group)
		else begin
			errors++;
			$display("Mismatch at %0t: pix_data_o expected %h got %h", $time,
				$sampled(exp_group), $sampled(pix_data));
		end

	a_user: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n)
		pix_valid && exp_pending |-> pix_user == exp_user)
		else begin
			errors++;
			$display("Mismatch at %0t: pix_user_o expected %b got %b", $time,
				$sampled(exp_user), $sampled(pix_user));
		end

	a_last: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n)
		pix_valid && exp_pending |-> pix_last == exp_last)
		else begin
			errors++;
			$display("Mismatch at %0t: pix_last_o expected %b got %b", $time,
				$sampled(exp_last), $sampled(pix_last));
		end

	a_strobes: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n)
		check_idle |-> !pix_valid && !pix_user && !pix_last)
		else begin
			errors++;
			$display("pixel strobes still high at %0t while the bus is idle", $time);
		end

	a_held_group: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n)
		check_idle |-> pix_data == final_group)
		else begin
			errors++;
			$display("Mismatch at %0t: pix_data_o expected %h got %h", $time,
				$sampled(final_group), $sampled(pix_data));
		end

	a_toggle: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n)
		check_idle |-> frame_toggle == fs_sent[0])
		else begin
			errors++;
			$display("Mismatch at %0t: frame_toggle_o expected %b got %b", $time,
				$sampled(fs_sent[0]), $sampled(frame_toggle));
		end

	a_frames: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n)
		check_idle |-> frame_count == fe_sent)
		else begin
			errors++;
			$display("Mismatch at %0t: frame_count_o expected %0d got %0d", $time,
				$sampled(fe_sent), $sampled(frame_count));
		end

	a_lines: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n)
		check_idle |-> line_count == last_lines)
		else begin
			errors++;
			$display("Mismatch at %0t: line_count_o expected %0d got %0d", $time,
				$sampled(last_lines), $sampled(line_count));
		end

	a_lane0: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n)
		check_idle |-> lane0_count == lane_active)
		else begin
			errors++;
			$display("Mismatch at %0t: lane0_count_o expected %0d got %0d", $time,
				$sampled(lane_active), $sampled(lane0_count));
		end

	a_lane1: assert property (@(posedge rxbyteclkhs) disable iff (!rst_n)
		check_idle |-> lane1_count == lane_active)
		else begin
			errors++;
			$display("Mismatch at %0t: lane1_count_o expected %0d got %0d", $time,
				$sampled(lane_active), $sampled(lane1_count));
		end

	// ----------------------------------------------------------
	// sequencing
	// ----------------------------------------------------------

	task automatic pulse_check();
		@(posedge rxbyteclkhs);
		check_idle <= 1'b1;
		@(posedge rxbyteclkhs);
		check_idle <= 1'b0;
		@(posedge rxbyteclkhs);
	endtask

	// all groups out and every frame end seen by the monitor
	task automatic wait_idle();
		int t;
		t = 0;
		while ((expect_q.size() > 0 || frame_count != fe_sent) && t < TIMEOUT) begin
			@(posedge rxbyteclkhs);
			t++;
		end
		if (t >= TIMEOUT) begin
			errors++;
			$display("timeout at %0t waiting for pixel groups and frame end", $time);
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors != errors_before)
			failed++;
		$display("test %0d %s: %s", tests, name, (errors != errors_before) ? "failed" : "ok");
		errors_before = errors;
	endtask

	initial begin
		rst_n      <= 1'b0;
		rxdatahs   <= '0;
		rxvalidhs  <= '0;
		rxactivehs <= '0;
		rxsynchs   <= '0;
		check_idle <= 1'b0;
		seed          = SEED;
		errors        = 0;
		errors_before = 0;
		tests         = 0;
		failed        = 0;
		fs_sent       = '0;
		fe_sent       = '0;
		last_lines    = '0;
		lane_active   = '0;
		final_group   = '0;
		for (int i = 0; i < LINES; i++)
			for (int j = 0; j < WORD_COUNT; j++)
				line_data[i][j] = 8'($random(seed));
		repeat (16) @(posedge rxbyteclkhs);
		rst_n <= 1'b1;

		pulse_check();
		finish_test("reset");

		send_frame(LINES, csi2_pkg::DT_RAW10, 0);
		wait_idle();
		pulse_check();
		finish_test("raw10 unpacking");

		// lane 1 two cycles behind lane 0
		send_frame(LINES, csi2_pkg::DT_RAW10, 2);
		wait_idle();
		pulse_check();
		finish_test("lane skew");

		send_frame(1, 6'h12, 0);
		wait_idle();
		pulse_check();
		finish_test("ignored data type");

		send_frame(2, csi2_pkg::DT_RAW10, 0);
		wait_idle();
		pulse_check();
		finish_test("monitor counters");

		$display("%0d tests, %0d failed, %0d check errors", tests, failed, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
design/csi2_pkg.sv
design/csi2_lane_merge.sv
design/csi2_packet_parser.sv
design/raw10_unpack.sv
design/frame_monitor.sv
design/csi2_cam_rx.sv
tb/tb_csi2_cam_rx.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_csi2_cam_rx
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
